// ==== logic/ls_pkg.sv ====
package ls_pkg;

  // ####################################################################
  // array sizes
  // ####################################################################
  localparam int COLUMNS = 4;                 // column units.
  localparam int LANES   = 8;                 // lanes per input word.
  localparam int LANE_W  = 8;                 // bits per lane.
  localparam int WORD_W  = LANES * LANE_W;    // packed input word.
  localparam int ACC_W   = 19;                // eight 8x8 products plus sign.

  // ####################################################################
  // vector types
  // ####################################################################
  typedef logic [WORD_W-1:0] word_t;                  // one input word.
  typedef logic signed [LANE_W-1:0] lane_t;           // one signed lane.
  typedef logic signed [ACC_W-1:0] acc_t;             // dot product or filtered result.
  typedef logic [$clog2(COLUMNS)-1:0] col_idx_t;      // column number.
  typedef logic [$clog2(LANES)-1:0] lane_idx_t;       // lane walk counter.

  // ####################################################################
  // state machines
  // ####################################################################
  // feeder handshake and batch stall
  typedef enum logic [1:0] {
    dm_idle,        // waiting for in_req.
    dm_acked,       // in_ack high, waiting for in_req to drop.
    dm_wait_drain   // batch loaded, input stalled.
  } demux_state_t;

  // drain output handshake
  typedef enum logic [1:0] {
    dr_collect,     // waiting for all columns.
    dr_offer,       // out_req high.
    dr_release      // waiting for out_ack to drop.
  } drain_state_t;

endpackage

// ==== logic/ls_input_demux.sv ====
module ls_input_demux import ls_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               in_req,
  input  word_t              in_data,
  input  logic               batch_free,
  output logic               in_ack,
  output logic [COLUMNS-1:0] load_weight,
  output logic [COLUMNS-1:0] load_act,
  output word_t              load_data,
  output logic               start
);

  localparam int CNT_W = $clog2(2 * COLUMNS);

  demux_state_t       state;
  logic [CNT_W-1:0]   word_cnt;     // 0..COLUMNS-1 weights, then activations.
  col_idx_t           col_sel;
  logic               is_weight;
  logic               last_word;
  logic [COLUMNS-1:0] col_onehot;
  logic               accept;

  // ####################################################################
  // steering decode
  // ####################################################################
  assign col_sel    = col_idx_t'(word_cnt % COLUMNS);  // word k -> column k mod COLUMNS.
  assign is_weight  = (word_cnt < COLUMNS);
  assign last_word  = (word_cnt == CNT_W'(2 * COLUMNS - 1));
  assign col_onehot = COLUMNS'(1) << col_sel;
  assign accept     = (state == dm_idle) && in_req;

  // ####################################################################
  // handshake, counter and load pulses
  // ####################################################################
  always_ff @(posedge clk) begin
    if (reset_n) begin
      state       <= dm_idle;
      in_ack      <= 1'b0;
      word_cnt    <= '0;
      load_weight <= '0;
      load_act    <= '0;
      start       <= 1'b0;
    end else begin
      load_weight <= '0;                    // pulses last one cycle.
      load_act    <= '0;
      // last activation always lands in the final column
      start       <= load_act[COLUMNS-1];
      case (state)
        dm_idle: begin
          if (in_req) begin
            in_ack <= 1'b1;
            if (is_weight) begin
              load_weight <= col_onehot;
            end else begin
              load_act <= col_onehot;
            end
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            state    <= dm_acked;
          end
        end
        dm_acked: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            // counter wrapped, so the batch is complete
            state  <= (word_cnt == '0) ? dm_wait_drain : dm_idle;
          end
        end
        dm_wait_drain: begin
          if (batch_free) begin
            state <= dm_idle;               // next batch may start.
          end
        end
        default: begin
          state <= dm_idle;
        end
      endcase
    end
  end

  // shared data bus to the columns
  always_ff @(posedge clk) begin
    if (accept) begin
      load_data <= in_data;                 // sampled with the ack edge.
    end
  end

endmodule

// ==== logic/ls_column.sv ====
module ls_column import ls_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  load_weight,
  input  logic  load_act,
  input  word_t load_data,
  input  logic  start,
  output acc_t  col_result,
  output logic  col_done
);

  word_t                     weight_q;
  word_t                     act_q;
  lane_idx_t                 lane_idx;    // sits at 0 between batches.
  logic                      busy;
  lane_t                     w_lane;
  lane_t                     a_lane;
  logic signed [2*LANE_W-1:0] prod;

  // ####################################################################
  // operand registers
  // ####################################################################
  always_ff @(posedge clk) begin
    if (load_weight) begin
      weight_q <= load_data;
    end
    if (load_act) begin
      act_q <= load_data;
    end
  end

  // current lane pair and its product
  assign w_lane = weight_q[lane_idx*LANE_W +: LANE_W];
  assign a_lane = act_q[lane_idx*LANE_W +: LANE_W];
  assign prod   = w_lane * a_lane;          // -128*-128 still fits.

  // ####################################################################
  // lane walk and accumulate
  // ####################################################################
  always_ff @(posedge clk) begin
    if (reset_n) begin
      lane_idx   <= '0;
      busy       <= 1'b0;
      col_done   <= 1'b0;
      col_result <= '0;
    end else if (start) begin
      // lane 0 goes in on the start edge, the old sum is dropped
      col_result <= acc_t'(prod);
      lane_idx   <= lane_idx + 1'b1;
      busy       <= 1'b1;
      col_done   <= 1'b0;
    end else if (busy) begin
      col_result <= col_result + prod;      // sign extended add.
      lane_idx   <= lane_idx + 1'b1;        // wraps back to 0.
      if (lane_idx == lane_idx_t'(LANES - 1)) begin
        busy     <= 1'b0;
        col_done <= 1'b1;                   // held until next start.
      end
    end
  end

endmodule

// ==== logic/filter_and_select.sv ====
module filter_and_select import ls_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  acc_t               col_result [COLUMNS],
  input  logic [COLUMNS-1:0] col_done,
  input  logic               out_ack,
  output logic               out_req,
  output col_idx_t           out_index,
  output acc_t               out_value,
  output logic               batch_free
);

  drain_state_t state;
  logic         done_q;       // all columns finished, one cycle late.
  logic         armed;        // cleared once a batch is served.
  logic         fire;
  acc_t         filtered [COLUMNS];
  acc_t         best_value;
  col_idx_t     best_index;

  // ####################################################################
  // relu filter and max select
  // ####################################################################
  always_comb begin
    for (int i = 0; i < COLUMNS; i++) begin
      filtered[i] = col_result[i][ACC_W-1] ? '0 : col_result[i];  // negative -> 0.
    end
  end

  // strict compare keeps the lowest index on a tie
  always_comb begin
    best_value = '0;
    best_index = '0;
    for (int i = 0; i < COLUMNS; i++) begin
      if (filtered[i] > best_value) begin
        best_value = filtered[i];
        best_index = col_idx_t'(i);
      end
    end
  end

  assign fire = (state == dr_collect) && done_q && armed;

  // ####################################################################
  // output handshake
  // ####################################################################
  always_ff @(posedge clk) begin
    if (reset_n) begin
      state      <= dr_collect;
      done_q     <= 1'b0;
      armed      <= 1'b1;
      out_req    <= 1'b0;
      batch_free <= 1'b0;
    end else begin
      done_q     <= &col_done;
      batch_free <= 1'b0;
      if (!done_q) begin
        armed <= 1'b1;                      // columns restarted.
      end
      case (state)
        dr_collect: begin
          if (fire) begin
            armed   <= 1'b0;
            out_req <= 1'b1;
            state   <= dr_offer;
          end
        end
        dr_offer: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= dr_release;
          end
        end
        dr_release: begin
          if (!out_ack) begin
            batch_free <= 1'b1;             // lets the feeder go on.
            state      <= dr_collect;
          end
        end
        default: begin
          state <= dr_collect;
        end
      endcase
    end
  end

  // result payload, held through offer and release
  always_ff @(posedge clk) begin
    if (fire) begin
      out_value <= best_value;
      out_index <= best_index;
    end
  end

endmodule

// ==== logic/ls_array.sv ====
module ls_array import ls_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     in_req,
  input  word_t    in_data,
  input  logic     out_ack,
  output logic     in_ack,
  output logic     out_req,
  output col_idx_t out_index,
  output acc_t     out_value
);

  logic [COLUMNS-1:0] load_weight;
  logic [COLUMNS-1:0] load_act;
  word_t              load_data;
  logic               start;
  acc_t               col_result [COLUMNS];
  logic [COLUMNS-1:0] col_done;
  logic               batch_free;

  // ####################################################################
  // feeder
  // ####################################################################
  ls_input_demux u_input_demux (
    .clk         (clk),
    .reset_n     (reset_n),
    .in_req      (in_req),
    .in_data     (in_data),
    .batch_free  (batch_free),
    .in_ack      (in_ack),
    .load_weight (load_weight),
    .load_act    (load_act),
    .load_data   (load_data),
    .start       (start)
  );

  // ####################################################################
  // columns
  // ####################################################################
  for (genvar c = 0; c < COLUMNS; c++) begin : g_col
    ls_column u_column (
      .clk         (clk),
      .reset_n     (reset_n),
      .load_weight (load_weight[c]),
      .load_act    (load_act[c]),
      .load_data   (load_data),       // shared bus.
      .start       (start),
      .col_result  (col_result[c]),
      .col_done    (col_done[c])
    );
  end

  // ####################################################################
  // drain
  // ####################################################################
  filter_and_select u_filter_and_select (
    .clk        (clk),
    .reset_n    (reset_n),
    .col_result (col_result),
    .col_done   (col_done),
    .out_ack    (out_ack),
    .out_req    (out_req),
    .out_index  (out_index),
    .out_value  (out_value),
    .batch_free (batch_free)
  );

endmodule

// ==== tests/ls_array_checker.sv ====
module ls_array_checker import ls_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     in_ack,
  input  logic     out_req,
  input  col_idx_t out_index,
  input  acc_t     out_value,
  input  int       test_num,
  input  col_idx_t exp_index,
  input  acc_t     exp_value,
  input  int       tb_fails,
  input  logic     report_now,
  output int       fail_total
);

  int       passed     = 0;
  int       failed     = 0;
  logic     reset_q    = 1'b0;
  logic     req_q      = 1'b0;
  logic     test_bad   = 1'b0;
  int       held_test  = 0;
  col_idx_t held_index = '0;
  acc_t     held_value = '0;

  assign fail_total = failed + tb_fails;

  // ####################################################################
  // reset state, first edge after release
  // ####################################################################
  always @(posedge clk) begin
    if (reset_q && !reset_n) begin
      test_bad = 1'b0;
      if (in_ack !== 1'b0) begin
        $display("Error at %0t: in_ack expected 0, got %b", $time, in_ack);
        test_bad = 1'b1;
      end
      if (out_req !== 1'b0) begin
        $display("Error at %0t: out_req expected 0, got %b", $time, out_req);
        test_bad = 1'b1;
      end
      if (test_bad) begin
        failed++;
        $display("reset: failed");
      end else begin
        passed++;
        $display("reset: passed, in_ack and out_req low");
      end
    end
    reset_q = reset_n;
  end

  // ####################################################################
  // result compare and output handshake watch
  // ####################################################################
  always @(posedge clk) begin
    if (!reset_n) begin
      if (out_req && !req_q) begin
        held_test  = test_num;                // test number may move on before the fall.
        held_index = out_index;
        held_value = out_value;
        test_bad   = 1'b0;
        if (out_index !== exp_index) begin
          $display("Error at %0t: out_index expected %0d, got %0d",
                   $time, exp_index, out_index);
          test_bad = 1'b1;
        end
        if (out_value !== exp_value) begin
          $display("Error at %0t: out_value expected %0d, got %0d",
                   $time, exp_value, out_value);
          test_bad = 1'b1;
        end
      end else if (out_req) begin
        if (out_index !== held_index) begin
          $display("Error at %0t: out_index expected %0d (held), got %0d",
                   $time, held_index, out_index);
          test_bad = 1'b1;
        end
        if (out_value !== held_value) begin
          $display("Error at %0t: out_value expected %0d (held), got %0d",
                   $time, held_value, out_value);
          test_bad = 1'b1;
        end
      end
      if (out_req && in_ack) begin
        $display("test %0d: in_ack rose while out_req was waiting for out_ack", held_test);
        test_bad = 1'b1;
      end
      if (!out_req && req_q) begin
        if (test_bad) begin
          failed++;
          $display("test %0d: failed", held_test);
        end else begin
          passed++;
          $display("test %0d: passed, index %0d value %0d", held_test, held_index, held_value);
        end
      end
    end
    req_q = out_req;
  end

  always @(posedge report_now) begin
    $display("summary: %0d passed, %0d failed", passed, failed + tb_fails);
  end

endmodule

// ==== tests/ls_array_tb.sv ====
module ls_array_tb import ls_pkg::*; ();

  localparam int N_FIXED    = 8;
  localparam int N_RAND     = 12;
  localparam int N_TESTS    = N_FIXED + N_RAND;
  localparam int WAIT_LIMIT = 200;            // cycles per handshake wait.

  logic     clk;
  logic     reset_n;
  logic     in_req;
  word_t    in_data;
  logic     out_ack;
  logic     in_ack;
  logic     out_req;
  col_idx_t out_index;
  acc_t     out_value;

  int       test_num;
  col_idx_t exp_index;
  acc_t     exp_value;
  int       tb_fails;
  logic     report_now;
  int       fail_total;
  logic     timed_out;

  // ####################################################################
  // stimulus table, one row per test
  // ####################################################################
  word_t    tbl_weight [N_TESTS][COLUMNS];
  word_t    tbl_act    [N_TESTS][COLUMNS];
  col_idx_t tbl_index  [N_TESTS];
  acc_t     tbl_value  [N_TESTS];
  int       tbl_delay  [N_TESTS];          // out_ack delay in cycles.
  logic     tbl_early  [N_TESTS];          // next batch requests during the wait.

  ls_array UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_req    (in_req),
    .in_data   (in_data),
    .out_ack   (out_ack),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_index (out_index),
    .out_value (out_value)
  );

  ls_array_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_index  (out_index),
    .out_value  (out_value),
    .test_num   (test_num),
    .exp_index  (exp_index),
    .exp_value  (exp_value),
    .tb_fails   (tb_fails),
    .report_now (report_now),
    .fail_total (fail_total)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic word_t splat(input logic [7:0] b);
    return {LANES{b}};                     // same byte in every lane.
  endfunction

  task automatic set_col(input int r, input int c, input word_t w, input word_t a);
    tbl_weight[r][c] = w;
    tbl_act[r][c]    = a;
  endtask

  task automatic set_expect(input int r, input int idx, input int val, input int delay);
    tbl_index[r] = col_idx_t'(idx);
    tbl_value[r] = acc_t'(val);
    tbl_delay[r] = delay;
    tbl_early[r] = 1'b0;
  endtask

  // signed dot product per column, negatives to zero, first maximum wins
  function automatic void expect_row(input int r);
    acc_t     sum;
    acc_t     best;
    col_idx_t idx;
    lane_t    w;
    lane_t    a;
    best = '0;
    idx  = '0;
    for (int c = 0; c < COLUMNS; c++) begin
      sum = '0;
      for (int l = 0; l < LANES; l++) begin
        w   = tbl_weight[r][c][l*LANE_W +: LANE_W];
        a   = tbl_act[r][c][l*LANE_W +: LANE_W];
        sum = sum + w * a;
      end
      if (sum < 0) sum = '0;
      if (sum > best) begin
        best = sum;
        idx  = col_idx_t'(c);
      end
    end
    tbl_index[r] = idx;
    tbl_value[r] = best;
  endfunction

  task automatic build_table();
    set_col(0, 0, splat(8'h80), splat(8'h80));              // -128 * -128 in all lanes.
    set_col(0, 1, {4{16'h7f80}}, splat(8'h7f));
    set_col(0, 2, splat(8'h01), 64'h0102_0304_fffe_fdfc);
    set_col(0, 3, splat(8'hff), splat(8'h80));
    set_expect(0, 0, 131072, 0);
    set_col(1, 0, splat(8'h02), splat(8'hfe));              // all sums negative.
    set_col(1, 1, splat(8'h10), splat(8'hf0));
    set_col(1, 2, splat(8'h80), splat(8'h7f));
    set_col(1, 3, splat(8'hff), splat(8'h01));
    set_expect(1, 0, 0, 1);
    set_col(2, 0, splat(8'h03), splat(8'hfd));
    set_col(2, 1, splat(8'h05), splat(8'hfb));
    set_col(2, 2, splat(8'h07), splat(8'h09));
    set_col(2, 3, splat(8'h80), splat(8'h01));
    set_expect(2, 2, 504, 2);
    set_col(3, 0, splat(8'h02), splat(8'h03));              // tie in columns 1 and 3.
    set_col(3, 1, splat(8'h04), splat(8'h05));
    set_col(3, 2, splat(8'h08), splat(8'hfe));
    set_col(3, 3, splat(8'h05), splat(8'h04));
    set_expect(3, 1, 160, 3);
    // distinct weights, the large activation walks across the columns
    for (int t = 0; t < COLUMNS; t++) begin
      for (int c = 0; c < COLUMNS; c++) begin
        set_col(4 + t, c, splat(8'(c + 1)), splat((c == t) ? 8'h10 : 8'h01));
      end
      set_expect(4 + t, t, 128 * (t + 1), t);
    end
    for (int r = N_FIXED; r < N_TESTS; r++) begin
      for (int c = 0; c < COLUMNS; c++) begin
        set_col(r, c, {$urandom, $urandom}, {$urandom, $urandom});
      end
      expect_row(r);
      tbl_delay[r] = $urandom % 21;
      tbl_early[r] = (r != N_TESTS - 1);
    end
  endtask

  // ####################################################################
  // four-phase drivers
  // ####################################################################
  task automatic send_word(input word_t data, input int word, input logic pre_raised);
    int n;
    if (!pre_raised) begin
      in_data = data;
      in_req  = 1'b1;
    end
    n = 0;
    while (!in_ack && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!in_ack) begin
      $display("in_ack never rose for word %0d of test %0d", word, test_num);
      timed_out = 1'b1;
    end else begin
      in_req = 1'b0;
      n = 0;
      while (in_ack && n < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        n++;
      end
      if (in_ack) begin
        $display("in_ack never fell for word %0d of test %0d", word, test_num);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic take_result(input int t);
    int n;
    n = 0;
    while (!out_req && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!out_req) begin
      $display("out_req never rose for test %0d", t);
      timed_out = 1'b1;
    end else begin
      if (tbl_early[t]) begin
        in_data = tbl_weight[t + 1][0];    // first word of the next batch waits.
        in_req  = 1'b1;
      end
      repeat (tbl_delay[t]) @(posedge clk);
      #1;
      out_ack = 1'b1;
      n = 0;
      while (out_req && n < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        n++;
      end
      if (out_req) begin
        $display("out_req never fell after out_ack for test %0d", t);
        timed_out = 1'b1;
      end
      out_ack = 1'b0;
    end
  endtask

  // ####################################################################
  // main sequence
  // ####################################################################
  initial begin
    reset_n    = 1'b1;
    in_req     = 1'b0;
    in_data    = '0;
    out_ack    = 1'b0;
    test_num   = 0;
    exp_index  = '0;
    exp_value  = '0;
    tb_fails   = 0;
    report_now = 1'b0;
    timed_out  = 1'b0;
    void'($urandom(32'h69a0));
    build_table();
    repeat (16) @(posedge clk);
    #1;
    reset_n = 1'b0;
    for (int t = 0; t < N_TESTS && !timed_out; t++) begin
      test_num  = t;
      exp_index = tbl_index[t];
      exp_value = tbl_value[t];
      for (int k = 0; k < 2 * COLUMNS && !timed_out; k++) begin
        send_word((k < COLUMNS) ? tbl_weight[t][k] : tbl_act[t][k - COLUMNS], k,
                  (k == 0) && (t > 0) && tbl_early[(t > 0) ? t - 1 : 0]);
      end
      if (!timed_out) take_result(t);
    end
    if (timed_out) tb_fails++;
    repeat (4) @(posedge clk);
    report_now = 1'b1;
    #1;
    if (fail_total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
logic/ls_pkg.sv
logic/ls_input_demux.sv
logic/ls_column.sv
logic/filter_and_select.sv
logic/ls_array.sv
tests/ls_array_checker.sv
tests/ls_array_tb.sv

// ==== Bender.yml ====
package:
  name: ls_array

sources:
  - logic/ls_pkg.sv
  - logic/ls_input_demux.sv
  - logic/ls_column.sv
  - logic/filter_and_select.sv
  - logic/ls_array.sv
  - target: test
    files:
      - tests/ls_array_checker.sv
      - tests/ls_array_tb.sv
